//--- design/mem_stage_macros.svh
`ifndef MEM_STAGE_MACROS_SVH
`define MEM_STAGE_MACROS_SVH

// Shared sizes for the memory-access stage

// Width of one data word in bits
`define MEM_DATA_W 32

// Byte-address bits decoded by the data memory
`define MEM_ADDR_W 12

// Number of words held by the data memory
// 2 ** MEM_ADDR_W bytes, four bytes per word
`define MEM_WORDS 1024

`endif

//--- design/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

  ////////////////////
  // Store width
  ////////////////////

  // Width of a store in EX/MEM
  // Encoded values match the cases file
  typedef enum logic [1:0] {
    st_none = 2'd0,
    st_byte = 2'd1,
    st_half = 2'd2,
    st_word = 2'd3
  } store_op_e;

  ////////////////////
  // Load kind
  ////////////////////

  // Load flavour carried into MEM/WB
  // Unsigned variants zero-extend, the rest sign-extend
  typedef enum logic [2:0] {
    ld_none = 3'd0,
    ld_b    = 3'd1,
    ld_h    = 3'd2,
    ld_w    = 3'd3,
    ld_bu   = 3'd4,
    ld_hu   = 3'd5
  } load_op_e;

endpackage

`default_nettype wire

//--- design/store_align.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_stage_macros.svh"

module store_align (
  input  mem_stage_pkg::store_op_e ex_mem_store_op,
  input  logic [1:0]               addr_low,
  input  logic [`MEM_DATA_W-1:0]   store_data,
  output logic [3:0]               byte_we,
  output logic [`MEM_DATA_W-1:0]   wdata
);

  // Doubled word so a plain shift acts as a rotate
  logic [2*`MEM_DATA_W-1:0] rot_word;
  // Halfword mask before folding the wrap back into lane 0
  logic [7:0]               half_mask;

  ////////////////////
  // Lane enables
  ////////////////////

  always_comb begin
    half_mask = 8'b0000_0011 << addr_low;
    unique case (ex_mem_store_op)
      // One lane picked by the offset
      mem_stage_pkg::st_byte: byte_we = 4'b0001 << addr_low;
      // Two lanes, offset 3 wraps to lanes 3 and 0
      mem_stage_pkg::st_half: byte_we = half_mask[3:0] | half_mask[7:4];
      // Full word ignores the offset
      mem_stage_pkg::st_word: byte_we = 4'b1111;
      // Not a store
      default: byte_we = 4'b0000;
    endcase
  end

  ////////////////////
  // Data rotation
  ////////////////////

  // Rotate left by 8 * offset
  // Byte 0 of the store data ends up in lane addr_low
  always_comb begin
    rot_word = {store_data, store_data} << {addr_low, 3'b000};
    wdata    = rot_word[2*`MEM_DATA_W-1:`MEM_DATA_W];
  end

endmodule

`default_nettype wire

//--- design/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_stage_macros.svh"

module data_ram (
  input  logic                   bus,
  input  logic                   rst_n,
  input  logic                   ram_en,
  input  logic                   ram_we,
  input  logic [3:0]             byte_we,
  input  logic [`MEM_ADDR_W-1:0] addr,
  input  logic [`MEM_DATA_W-1:0] wdata,
  output logic [`MEM_DATA_W-1:0] rdata
);

  // Word storage
  logic [`MEM_DATA_W-1:0] mem [`MEM_WORDS];
  // Word index, the byte offset bits dropped
  logic [`MEM_ADDR_W-3:0] word_addr;

  assign word_addr = addr[`MEM_ADDR_W-1:2];

  ////////////////////
  // Write port
  ////////////////////

  // Per-lane write, only enabled lanes change
  always_ff @(posedge bus) begin
    if (ram_we) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (byte_we[lane]) begin
          mem[word_addr][8*lane +: 8] <= wdata[8*lane +: 8];
        end
      end
    end
  end

  ////////////////////
  // Read port
  ////////////////////

  // Registered read, old data on a same-cycle write
  // Held while ram_en is low
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else if (ram_en) begin
      rdata <= mem[word_addr];
    end
  end

  // A write strobe with no lane selected means the store decode went wrong
  a_we_has_lane : assert property (@(posedge bus) disable iff (!rst_n)
    ram_we |-> (byte_we != 4'b0000));

endmodule

`default_nettype wire

//--- design/load_extract.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_stage_macros.svh"

module load_extract (
  input  logic [`MEM_DATA_W-1:0]  rdata,
  input  logic [1:0]              byte_offset,
  input  mem_stage_pkg::load_op_e load_kind,
  output logic [`MEM_DATA_W-1:0]  memres
);

  // Doubled read word for the right rotate
  logic [2*`MEM_DATA_W-1:0] rot_word;
  // Addressed byte or halfword now sits in lane 0
  logic [`MEM_DATA_W-1:0]   lane0_word;

  ////////////////////
  // Lane rotation
  ////////////////////

  // Rotate right by 8 * offset
  always_comb begin
    rot_word   = {rdata, rdata} >> {byte_offset, 3'b000};
    lane0_word = rot_word[`MEM_DATA_W-1:0];
  end

  ////////////////////
  // Extension
  ////////////////////

  always_comb begin
    unique case (load_kind)
      // Sign-extended byte
      mem_stage_pkg::ld_b:
        memres = {{(`MEM_DATA_W-8){lane0_word[7]}}, lane0_word[7:0]};
      // Sign-extended halfword
      mem_stage_pkg::ld_h:
        memres = {{(`MEM_DATA_W-16){lane0_word[15]}}, lane0_word[15:0]};
      // Whole word, offset is zero for aligned lw
      mem_stage_pkg::ld_w:
        memres = lane0_word;
      // Zero-extended byte
      mem_stage_pkg::ld_bu:
        memres = {{(`MEM_DATA_W-8){1'b0}}, lane0_word[7:0]};
      // Zero-extended halfword
      mem_stage_pkg::ld_hu:
        memres = {{(`MEM_DATA_W-16){1'b0}}, lane0_word[15:0]};
      // No load in MEM/WB
      default:
        memres = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/mem_stage_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_stage_macros.svh"

module mem_stage_ctrl (
  input  logic                    bus,
  input  logic                    rst_n,
  input  logic                    hold,
  input  logic [`MEM_DATA_W-1:0]  ex_mem_alures,
  input  logic [`MEM_DATA_W-1:0]  ex_mem_dout_rs2,
  input  logic [4:0]              ex_mem_rs2,
  input  logic [4:0]              ex_mem_rd,
  input  logic                    ex_mem_regwrite,
  input  logic                    ex_mem_memread,
  input  logic                    ex_mem_memwrite,
  input  mem_stage_pkg::load_op_e ex_mem_load_op,
  input  logic [`MEM_DATA_W-1:0]  wb_res,
  output logic [`MEM_DATA_W-1:0]  mem_wb_alures,
  output logic [4:0]              mem_wb_rd,
  output logic                    mem_wb_regwrite,
  output logic                    mem_wb_memread,
  output mem_stage_pkg::load_op_e load_kind,
  output logic [1:0]              byte_offset,
  output logic [`MEM_DATA_W-1:0]  store_data,
  output logic                    ram_en,
  output logic                    ram_we
);

  // Store source comes from the instruction now in writeback
  logic fwd_sel;

  ////////////////////
  // Memory strobes
  ////////////////////

  // Hold freezes the read register and blocks writes
  assign ram_en = !hold;
  assign ram_we = ex_mem_memwrite && !hold;

  ////////////////////
  // Store forwarding
  ////////////////////

  // x0 never forwards, its value is always zero
  assign fwd_sel = ex_mem_memwrite && mem_wb_regwrite &&
                   (mem_wb_rd != 5'd0) && (mem_wb_rd == ex_mem_rs2);
  assign store_data = fwd_sel ? wb_res : ex_mem_dout_rs2;

  ////////////////////
  // MEM/WB register
  ////////////////////

  // Control part, cleared by reset
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      mem_wb_rd       <= 5'd0;
      mem_wb_regwrite <= 1'b0;
      mem_wb_memread  <= 1'b0;
      load_kind       <= mem_stage_pkg::ld_none;
      byte_offset     <= 2'd0;
    end else if (!hold) begin
      mem_wb_rd       <= ex_mem_rd;
      mem_wb_regwrite <= ex_mem_regwrite;
      mem_wb_memread  <= ex_mem_memread;
      load_kind       <= ex_mem_load_op;
      byte_offset     <= ex_mem_alures[1:0];
    end
  end

  // ALU result payload
  always_ff @(posedge bus) begin
    if (!hold) begin
      mem_wb_alures <= ex_mem_alures;
    end
  end

  // One instruction is either a load or a store
  a_rd_wr_excl : assert property (@(posedge bus) disable iff (!rst_n)
    !(ex_mem_memread && ex_mem_memwrite));

  // Memory write must not carry a load kind into MEM/WB
  a_we_no_load : assert property (@(posedge bus) disable iff (!rst_n)
    ram_we |-> (ex_mem_load_op == mem_stage_pkg::ld_none));

endmodule

`default_nettype wire

//--- design/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_stage_macros.svh"

module mem_stage (
  input  logic                     bus,
  input  logic                     rst_n,
  input  logic                     hold,
  input  logic [`MEM_DATA_W-1:0]   ex_mem_alures,
  input  logic [`MEM_DATA_W-1:0]   ex_mem_dout_rs2,
  input  logic [4:0]               ex_mem_rs2,
  input  logic [4:0]               ex_mem_rd,
  input  logic                     ex_mem_regwrite,
  input  logic                     ex_mem_memread,
  input  logic                     ex_mem_memwrite,
  input  mem_stage_pkg::store_op_e ex_mem_store_op,
  input  mem_stage_pkg::load_op_e  ex_mem_load_op,
  input  logic [`MEM_DATA_W-1:0]   wb_res,
  output logic [`MEM_DATA_W-1:0]   mem_wb_alures,
  output logic [`MEM_DATA_W-1:0]   mem_wb_memres,
  output logic [4:0]               mem_wb_rd,
  output logic                     mem_wb_regwrite,
  output logic                     mem_wb_memread
);

  // Control to datapath
  logic [`MEM_DATA_W-1:0]  store_data;
  logic                    ram_en;
  logic                    ram_we;
  mem_stage_pkg::load_op_e load_kind;
  logic [1:0]              byte_offset;
  // Store path into the memory
  logic [3:0]              byte_we;
  logic [`MEM_DATA_W-1:0]  wdata;
  // Registered read word
  logic [`MEM_DATA_W-1:0]  rdata;

  ////////////////////
  // Control
  ////////////////////

  mem_stage_ctrl i_mem_stage_ctrl (
    .bus             (bus),
    .rst_n           (rst_n),
    .hold            (hold),
    .ex_mem_alures   (ex_mem_alures),
    .ex_mem_dout_rs2 (ex_mem_dout_rs2),
    .ex_mem_rs2      (ex_mem_rs2),
    .ex_mem_rd       (ex_mem_rd),
    .ex_mem_regwrite (ex_mem_regwrite),
    .ex_mem_memread  (ex_mem_memread),
    .ex_mem_memwrite (ex_mem_memwrite),
    .ex_mem_load_op  (ex_mem_load_op),
    .wb_res          (wb_res),
    .mem_wb_alures   (mem_wb_alures),
    .mem_wb_rd       (mem_wb_rd),
    .mem_wb_regwrite (mem_wb_regwrite),
    .mem_wb_memread  (mem_wb_memread),
    .load_kind       (load_kind),
    .byte_offset     (byte_offset),
    .store_data      (store_data),
    .ram_en          (ram_en),
    .ram_we          (ram_we)
  );

  ////////////////////
  // Datapath
  ////////////////////

  // Offset bits pick the lanes
  store_align i_store_align (
    .ex_mem_store_op (ex_mem_store_op),
    .addr_low        (ex_mem_alures[1:0]),
    .store_data      (store_data),
    .byte_we         (byte_we),
    .wdata           (wdata)
  );

  // Low address bits of the ALU result index the memory
  data_ram i_data_ram (
    .bus     (bus),
    .rst_n   (rst_n),
    .ram_en  (ram_en),
    .ram_we  (ram_we),
    .byte_we (byte_we),
    .addr    (ex_mem_alures[`MEM_ADDR_W-1:0]),
    .wdata   (wdata),
    .rdata   (rdata)
  );

  load_extract i_load_extract (
    .rdata       (rdata),
    .byte_offset (byte_offset),
    .load_kind   (load_kind),
    .memres      (mem_wb_memres)
  );

endmodule

`default_nettype wire

//--- testbench/mem_stage_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_stage_macros.svh"

module mem_stage_checker (
  input  logic                     bus,
  input  logic                     rst_n,
  input  logic                     hold,
  input  logic [`MEM_DATA_W-1:0]   ex_mem_alures,
  input  logic [`MEM_DATA_W-1:0]   ex_mem_dout_rs2,
  input  logic [4:0]               ex_mem_rs2,
  input  logic [4:0]               ex_mem_rd,
  input  logic                     ex_mem_regwrite,
  input  logic                     ex_mem_memread,
  input  logic                     ex_mem_memwrite,
  input  mem_stage_pkg::store_op_e ex_mem_store_op,
  input  mem_stage_pkg::load_op_e  ex_mem_load_op,
  input  logic [`MEM_DATA_W-1:0]   wb_res,
  input  logic [`MEM_DATA_W-1:0]   mem_wb_alures,
  input  logic [`MEM_DATA_W-1:0]   mem_wb_memres,
  input  logic [4:0]               mem_wb_rd,
  input  logic                     mem_wb_regwrite,
  input  logic                     mem_wb_memread,
  input  int                       case_id,
  input  logic [`MEM_DATA_W-1:0]   exp_load,
  output int                       value_errs,
  output int                       ctrl_errs,
  output int                       checks
);

  // Byte model of the data memory
  logic [7:0]             model_mem [0:(1 << `MEM_ADDR_W)-1];
  // Predicted MEM/WB state
  logic [`MEM_DATA_W-1:0] p_alures;
  logic [`MEM_DATA_W-1:0] p_memres;
  logic [4:0]             p_rd;
  logic                   p_regwrite;
  logic                   p_memread;
  // No reset on the ALU payload, unknown until the first move
  logic                   alures_known;
  // Case that left the predicted state, 0 is reset
  int                     p_case;
  // Load result given by the cases file
  logic                   file_check;
  logic [`MEM_DATA_W-1:0] file_exp;

  ////////////////////
  // Reference model
  ////////////////////

  // Byte k of the data goes to lane offset plus k, wrapping in the word
  task automatic apply_store(input logic [`MEM_ADDR_W-1:0] addr,
                             input mem_stage_pkg::store_op_e width,
                             input logic [`MEM_DATA_W-1:0] data);
    int         nbytes;
    int         k;
    logic [1:0] lane;
    case (width)
      mem_stage_pkg::st_byte: nbytes = 1;
      mem_stage_pkg::st_half: nbytes = 2;
      mem_stage_pkg::st_word: nbytes = 4;
      default:                nbytes = 0;
    endcase
    for (k = 0; k < nbytes; k++) begin
      lane = addr[1:0] + k[1:0];
      model_mem[{addr[`MEM_ADDR_W-1:2], lane}] = data[8*k +: 8];
    end
  endtask

  // Gather bytes from the offset upward, then extend
  function automatic logic [`MEM_DATA_W-1:0] predict_load(
      input logic [`MEM_ADDR_W-1:0] addr, input mem_stage_pkg::load_op_e kind);
    logic [`MEM_DATA_W-1:0] word;
    logic [1:0]             lane;
    int                     k;
    for (k = 0; k < 4; k++) begin
      lane = addr[1:0] + k[1:0];
      word[8*k +: 8] = model_mem[{addr[`MEM_ADDR_W-1:2], lane}];
    end
    case (kind)
      mem_stage_pkg::ld_b:  return {{24{word[7]}}, word[7:0]};
      mem_stage_pkg::ld_h:  return {{16{word[15]}}, word[15:0]};
      mem_stage_pkg::ld_w:  return word;
      mem_stage_pkg::ld_bu: return {24'd0, word[7:0]};
      mem_stage_pkg::ld_hu: return {16'd0, word[15:0]};
      default:              return '0;
    endcase
  endfunction

  // One comparison, reported at once on mismatch
  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act, input bit is_value);
    checks = checks + 1;
    if (act !== exp) begin
      if (is_value) begin
        value_errs = value_errs + 1;
      end else begin
        ctrl_errs = ctrl_errs + 1;
      end
      $display("FAILED case %0d %s expected 0x%08h actual 0x%08h", p_case, name, exp, act);
    end
  endtask

  ////////////////////
  // Watcher
  ////////////////////

  // Inputs and outputs are both settled at the falling edge
  always @(negedge bus) begin
    logic                   fwd;
    logic [`MEM_DATA_W-1:0] sdata;
    if (!rst_n) begin
      p_memres     = '0;
      p_rd         = 5'd0;
      p_regwrite   = 1'b0;
      p_memread    = 1'b0;
      alures_known = 1'b0;
      p_case       = 0;
      file_check   = 1'b0;
      value_errs   = 0;
      ctrl_errs    = 0;
      checks       = 0;
    end else begin
      // Outputs left by the last instruction that moved
      check_value("mem_wb_regwrite", 32'(p_regwrite), 32'(mem_wb_regwrite), 1'b0);
      check_value("mem_wb_memread", 32'(p_memread), 32'(mem_wb_memread), 1'b0);
      check_value("mem_wb_rd", 32'(p_rd), 32'(mem_wb_rd), 1'b0);
      if (alures_known) begin
        check_value("mem_wb_alures", p_alures, mem_wb_alures, 1'b0);
      end
      check_value("mem_wb_memres", p_memres, mem_wb_memres, 1'b1);
      if (file_check) begin
        check_value("mem_wb_memres vs file", file_exp, mem_wb_memres, 1'b1);
      end
      // Instruction now on EX/MEM moves at the next edge unless held
      if (!hold) begin
        p_memres = predict_load(ex_mem_alures[`MEM_ADDR_W-1:0], ex_mem_load_op);
        if (ex_mem_memwrite) begin
          // Forward from the instruction in writeback, never from x0
          fwd   = p_regwrite && (p_rd != 5'd0) && (p_rd == ex_mem_rs2);
          sdata = fwd ? wb_res : ex_mem_dout_rs2;
          apply_store(ex_mem_alures[`MEM_ADDR_W-1:0], ex_mem_store_op, sdata);
        end
        p_alures     = ex_mem_alures;
        p_rd         = ex_mem_rd;
        p_regwrite   = ex_mem_regwrite;
        p_memread    = ex_mem_memread;
        alures_known = 1'b1;
        p_case       = case_id;
        file_check   = ex_mem_memread;
        file_exp     = exp_load;
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_stage_macros.svh"

module tb_mem_stage;

  // Half of the 40 ns clock period
  localparam int HALF_PERIOD = 20;
  // Room for the cases read from the file
  localparam int MAX_CASES = 128;

  logic                     bus;
  logic                     rst_n;
  logic                     hold;
  logic [`MEM_DATA_W-1:0]   ex_mem_alures;
  logic [`MEM_DATA_W-1:0]   ex_mem_dout_rs2;
  logic [4:0]               ex_mem_rs2;
  logic [4:0]               ex_mem_rd;
  logic                     ex_mem_regwrite;
  logic                     ex_mem_memread;
  logic                     ex_mem_memwrite;
  mem_stage_pkg::store_op_e ex_mem_store_op;
  mem_stage_pkg::load_op_e  ex_mem_load_op;
  logic [`MEM_DATA_W-1:0]   wb_res;
  logic [`MEM_DATA_W-1:0]   mem_wb_alures;
  logic [`MEM_DATA_W-1:0]   mem_wb_memres;
  logic [4:0]               mem_wb_rd;
  logic                     mem_wb_regwrite;
  logic                     mem_wb_memread;

  // Case number and file load result, handed to the checker
  int                       case_id;
  logic [`MEM_DATA_W-1:0]   exp_load;
  // Counts kept by the checker
  int                       value_errs;
  int                       ctrl_errs;
  int                       checks;

  // Columns of each case line, index 0 unused
  logic [31:0]              cases [0:MAX_CASES-1][0:10];
  int                       num_cases;
  // Run length guard
  int                       cycles;
  int                       cycle_limit;
  // Seed for the random hold cycles
  int                       seed;

  ////////////////////
  // Clock and timeout
  ////////////////////

  initial bus = 1'b0;
  always #HALF_PERIOD bus = ~bus;

  always @(posedge bus) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////
  // DUT and checker
  ////////////////////

  mem_stage i_mem_stage (
    .bus             (bus),
    .rst_n           (rst_n),
    .hold            (hold),
    .ex_mem_alures   (ex_mem_alures),
    .ex_mem_dout_rs2 (ex_mem_dout_rs2),
    .ex_mem_rs2      (ex_mem_rs2),
    .ex_mem_rd       (ex_mem_rd),
    .ex_mem_regwrite (ex_mem_regwrite),
    .ex_mem_memread  (ex_mem_memread),
    .ex_mem_memwrite (ex_mem_memwrite),
    .ex_mem_store_op (ex_mem_store_op),
    .ex_mem_load_op  (ex_mem_load_op),
    .wb_res          (wb_res),
    .mem_wb_alures   (mem_wb_alures),
    .mem_wb_memres   (mem_wb_memres),
    .mem_wb_rd       (mem_wb_rd),
    .mem_wb_regwrite (mem_wb_regwrite),
    .mem_wb_memread  (mem_wb_memread)
  );

  mem_stage_checker i_checker (
    .bus             (bus),
    .rst_n           (rst_n),
    .hold            (hold),
    .ex_mem_alures   (ex_mem_alures),
    .ex_mem_dout_rs2 (ex_mem_dout_rs2),
    .ex_mem_rs2      (ex_mem_rs2),
    .ex_mem_rd       (ex_mem_rd),
    .ex_mem_regwrite (ex_mem_regwrite),
    .ex_mem_memread  (ex_mem_memread),
    .ex_mem_memwrite (ex_mem_memwrite),
    .ex_mem_store_op (ex_mem_store_op),
    .ex_mem_load_op  (ex_mem_load_op),
    .wb_res          (wb_res),
    .mem_wb_alures   (mem_wb_alures),
    .mem_wb_memres   (mem_wb_memres),
    .mem_wb_rd       (mem_wb_rd),
    .mem_wb_regwrite (mem_wb_regwrite),
    .mem_wb_memread  (mem_wb_memread),
    .case_id         (case_id),
    .exp_load        (exp_load),
    .value_errs      (value_errs),
    .ctrl_errs       (ctrl_errs),
    .checks          (checks)
  );

  ////////////////////
  // Stimulus tasks
  ////////////////////

  // Fill cases[1..] from the file, comment and blank lines skipped
  task automatic read_cases();
    int    fd;
    int    n;
    string line;
    num_cases = 0;
    fd = $fopen("testbench/mem_stage_cases.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd) && num_cases < MAX_CASES - 1) begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                      cases[num_cases+1][0], cases[num_cases+1][1], cases[num_cases+1][2],
                      cases[num_cases+1][3], cases[num_cases+1][4], cases[num_cases+1][5],
                      cases[num_cases+1][6], cases[num_cases+1][7], cases[num_cases+1][8],
                      cases[num_cases+1][9], cases[num_cases+1][10]);
          if (n == 11) begin
            num_cases = num_cases + 1;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Present one EX/MEM instruction on the next rising edge
  task automatic drive_case(input int idx);
    @(posedge bus);
    case_id         <= idx;
    ex_mem_memread  <= (cases[idx][0] == 32'd1);
    ex_mem_memwrite <= (cases[idx][0] == 32'd2);
    ex_mem_store_op <= mem_stage_pkg::store_op_e'(cases[idx][1][1:0]);
    ex_mem_load_op  <= mem_stage_pkg::load_op_e'(cases[idx][2][2:0]);
    ex_mem_alures   <= cases[idx][3];
    ex_mem_dout_rs2 <= cases[idx][4];
    ex_mem_rs2      <= cases[idx][5][4:0];
    ex_mem_rd       <= cases[idx][6][4:0];
    ex_mem_regwrite <= cases[idx][7][0];
    wb_res          <= cases[idx][8];
    hold            <= cases[idx][9][0];
    exp_load        <= cases[idx][10];
  endtask

  // Stall one cycle, the presented instruction stays on the inputs
  task automatic insert_hold();
    @(posedge bus);
    hold <= 1'b1;
  endtask

  // Bubble with no memory access and no register write
  task automatic drive_nop(input int idx);
    @(posedge bus);
    case_id         <= idx;
    hold            <= 1'b0;
    ex_mem_memread  <= 1'b0;
    ex_mem_memwrite <= 1'b0;
    ex_mem_regwrite <= 1'b0;
    ex_mem_store_op <= mem_stage_pkg::st_none;
    ex_mem_load_op  <= mem_stage_pkg::ld_none;
    ex_mem_alures   <= '0;
    ex_mem_rd       <= 5'd0;
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int idx;
    int rnd;
    rst_n           = 1'b0;
    hold            = 1'b0;
    ex_mem_alures   = '0;
    ex_mem_dout_rs2 = '0;
    ex_mem_rs2      = 5'd0;
    ex_mem_rd       = 5'd0;
    ex_mem_regwrite = 1'b0;
    ex_mem_memread  = 1'b0;
    ex_mem_memwrite = 1'b0;
    ex_mem_store_op = mem_stage_pkg::st_none;
    ex_mem_load_op  = mem_stage_pkg::ld_none;
    wb_res          = '0;
    case_id         = 0;
    exp_load        = '0;
    cycles          = 0;
    cycle_limit     = 0;
    seed            = 51;
    read_cases();
    if (num_cases == 0) begin
      $display("No cases could be read from testbench/mem_stage_cases.txt");
      $display("SIMULATION FAILED");
    end else begin
      // Worst case is one case cycle plus one hold cycle
      cycle_limit = 4 * num_cases + 20;
      repeat (2) @(posedge bus);
      rst_n <= 1'b1;
      for (idx = 1; idx <= num_cases; idx++) begin
        drive_case(idx);
        rnd = $random(seed);
        if (rnd[0]) begin
          insert_hold();
        end
      end
      // Let the last instruction reach MEM/WB and be compared
      drive_nop(num_cases + 1);
      repeat (2) @(posedge bus);
      $display("Checks: %0d, value errors: %0d, control errors: %0d",
               checks, value_errs, ctrl_errs);
      if (value_errs == 0 && ctrl_errs == 0) begin
        $display("SIMULATION PASSED");
      end else begin
        $display("SIMULATION FAILED");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/mem_stage_cases.txt
# kind(0 alu,1 load,2 store) st_op ld_op addr store_data rs2 rd regwrite wb_res hold expect
# All fields hex, expect is the load result and only used for loads
2 3 0 100 11223344 2 0 0 0 0 0
2 3 0 104 a5b6c7d8 2 0 0 0 0 0
1 0 3 100 0 0 a 1 0 0 11223344
1 0 3 104 0 0 b 1 0 0 a5b6c7d8
0 0 0 0000abcd 0 0 6 1 0 0 0
2 3 0 200 8899aabb 2 0 0 0 0 0
2 1 0 200 000000cc 2 0 0 0 0 0
2 1 0 202 000000ee 2 0 0 0 0 0
1 0 3 200 0 0 a 1 0 0 88eeaacc
2 3 0 204 01234567 2 0 0 0 0 0
2 2 0 205 0000f00d 2 0 0 0 0 0
1 0 3 204 0 0 a 1 0 0 01f00d67
2 3 0 208 76543210 2 0 0 0 0 0
2 2 0 20b 0000beef 2 0 0 0 0 0
1 0 3 208 0 0 a 1 0 0 ef5432be
2 1 0 209 0000005a 2 0 0 0 0 0
2 1 0 20b 00000096 2 0 0 0 0 0
1 0 3 208 0 0 a 1 0 0 96545abe
2 2 0 20a 00001357 2 0 0 0 0 0
1 0 3 208 0 0 a 1 0 0 13575abe
2 3 0 300 f18293a4 2 0 0 0 0 0
1 0 1 300 0 0 a 1 0 0 ffffffa4
1 0 4 301 0 0 a 1 0 0 00000093
1 0 1 302 0 0 a 1 0 0 ffffff82
1 0 4 303 0 0 a 1 0 0 000000f1
1 0 1 301 0 0 a 1 0 0 ffffff93
1 0 4 300 0 0 a 1 0 0 000000a4
1 0 2 300 0 0 a 1 0 0 ffff93a4
1 0 5 302 0 0 a 1 0 0 0000f182
1 0 2 301 0 0 a 1 0 0 ffff8293
1 0 5 303 0 0 a 1 0 0 0000a4f1
1 0 2 302 0 0 a 1 0 0 fffff182
1 0 1 100 0 0 a 1 0 0 00000044
1 0 2 102 0 0 a 1 0 0 00001122
0 0 0 00000042 0 0 7 1 0 0 0
2 3 0 400 deadbeef 7 0 0 cafef00d 0 0
1 0 3 400 0 0 a 1 0 0 cafef00d
0 0 0 00000043 0 0 0 1 0 0 0
2 3 0 404 12345678 0 0 0 99999999 0 0
1 0 3 404 0 0 a 1 0 0 12345678
0 0 0 00000044 0 0 8 0 0 0 0
2 3 0 408 0badf00d 8 0 0 77777777 0 0
1 0 3 408 0 0 a 1 0 0 0badf00d
0 0 0 00000045 0 0 9 1 0 0 0
2 1 0 409 00000011 9 0 0 000000c3 0 0
1 0 3 408 0 0 a 1 0 0 0badc30d
2 3 0 500 13572468 2 0 0 0 0 0
2 3 0 500 ffffffff 2 0 0 0 1 0
1 0 3 500 0 0 a 1 0 0 13572468
0 0 0 deadbeef 0 0 c 1 0 1 0
1 0 4 503 0 0 a 1 0 0 00000013

//--- project.f
+incdir+design
design/mem_stage_pkg.sv
design/store_align.sv
design/data_ram.sv
design/load_extract.sv
design/mem_stage_ctrl.sv
design/mem_stage.sv
testbench/mem_stage_checker.sv
testbench/tb_mem_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_mem_stage -o tb_mem_stage

sim_out="$(./obj_dir/tb_mem_stage)"
echo "$sim_out"

if echo "$sim_out" | grep -qx "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi
